/* hdl/tl_cfg_pkg.sv */
// ----------------------------
// sizes and timing constants of the traffic-light controller
// ----------------------------
package tl_cfg_pkg;

  // second counts, phase lengths and remain
  localparam int CNT_W = 11;

  // binary display value, up to 2359 for the clock
  localparam int DISP_W = 14;

  localparam logic [CNT_W-1:0] GREEN_DEFAULT = CNT_W'(30);
  localparam logic [CNT_W-1:0] YELLOW_DEFAULT = CNT_W'(5);
  localparam logic [CNT_W-1:0] INTERRUPT_SEC = CNT_W'(5);

  // main road peak hours, both ends inclusive
  localparam int unsigned PEAK_AM_FIRST = 7;
  localparam int unsigned PEAK_AM_LAST = 9;
  localparam int unsigned PEAK_PM_FIRST = 17;
  localparam int unsigned PEAK_PM_LAST = 19;

endpackage

/* hdl/tl_phase_pkg.sv */
// ----------------------------
// controller phases and the operating mode codes
// ----------------------------
package tl_phase_pkg;

  // G = through green, L = left turn, Y = the yellow that follows
  typedef enum logic [3:0] {
    NIGHT = 4'd0,
    G1    = 4'd1,
    G1_Y  = 4'd2,
    G1L   = 4'd3,
    G1L_Y = 4'd4,
    G2    = 4'd5,
    G2_Y  = 4'd6,
    G2L   = 4'd7,
    G2L_Y = 4'd8,
    // manual interrupt yellows, then green for that group
    INT1  = 4'd9,
    INT2  = 4'd10
  } phase_t;

  // encoding of the two-bit mode switch
  typedef enum logic [1:0] {
    MODE_RUN        = 2'b00,
    MODE_NIGHT      = 2'b01,
    MODE_SET_GREEN  = 2'b10,
    MODE_SET_YELLOW = 2'b11
  } mode_t;

endpackage

/* hdl/tl_phase_if.sv */
// ----------------------------
// phase state and phase lengths shared inside the controller
// ----------------------------
`timescale 1ns/1ns

interface tl_phase_if;

  tl_phase_pkg::phase_t phase;
  logic [tl_cfg_pkg::CNT_W-1:0] remain;
  logic [tl_cfg_pkg::CNT_W-1:0] green_len;
  logic [tl_cfg_pkg::CNT_W-1:0] yellow_len;

  modport fsm (output phase, output remain, input green_len, input yellow_len);

  modport settings (output green_len, output yellow_len);

  modport view (input phase, input remain, input green_len, input yellow_len);

endinterface

/* hdl/key_sync.sv */
// ----------------------------
// key synchronizer with one-cycle release pulses, mode decode
// ----------------------------
`timescale 1ns/1ns

module key_sync (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [1:0]            i_mode,
  input  logic                  i_key_plus,
  input  logic                  i_key_sub,
  output tl_phase_pkg::mode_t   o_mode,
  output logic                  o_plus_pulse,
  output logic                  o_sub_pulse
);

  // bit 1 plus, bit 0 sub
  logic [1:0] key_s1;
  logic [1:0] key_s2;
  logic [1:0] release_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_s1    <= 2'b00;
      key_s2    <= 2'b00;
      release_q <= 2'b00;
    end else begin
      key_s1    <= {i_key_plus, i_key_sub};
      key_s2    <= key_s1;
      // high in s2, already low in s1
      release_q <= key_s2 & ~key_s1;
    end
  end

  assign o_plus_pulse = release_q[1];
  assign o_sub_pulse  = release_q[0];

  assign o_mode = tl_phase_pkg::mode_t'(i_mode);

endmodule

/* hdl/sec_clock.sv */
// ----------------------------
// second tick from clk, time-of-day counter and peak-hour flag
// ----------------------------
`timescale 1ns/1ns

module sec_clock #(
  parameter int unsigned TICKS_PER_SEC = 12_000_000,
  parameter int unsigned RESET_HOUR    = 0
) (
  input  logic                            clk,
  input  logic                            rst_n,
  output logic                            o_tick,
  output logic                            o_peak,
  output logic [tl_cfg_pkg::DISP_W-1:0]   o_hhmm
);

  localparam int DIV_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
  localparam int DW = tl_cfg_pkg::DISP_W;

  logic [DIV_W-1:0] div_cnt;
  logic [5:0]       sec_cnt;
  logic [5:0]       min_cnt;
  logic [4:0]       hour_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      o_tick  <= 1'b0;
    end else if (div_cnt == DIV_W'(TICKS_PER_SEC - 1)) begin
      div_cnt <= '0;
      o_tick  <= 1'b1;
    end else begin
      div_cnt <= div_cnt + 1'b1;
      o_tick  <= 1'b0;
    end
  end

  // ripple carry sec -> min -> hour
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sec_cnt  <= '0;
      min_cnt  <= '0;
      hour_cnt <= 5'(RESET_HOUR);
    end else if (o_tick) begin
      if (sec_cnt == 6'd59) begin
        sec_cnt <= '0;
        if (min_cnt == 6'd59) begin
          min_cnt  <= '0;
          hour_cnt <= (hour_cnt == 5'd23) ? 5'd0 : hour_cnt + 1'b1;
        end else begin
          min_cnt <= min_cnt + 1'b1;
        end
      end else begin
        sec_cnt <= sec_cnt + 1'b1;
      end
    end
  end

  assign o_peak = (hour_cnt >= tl_cfg_pkg::PEAK_AM_FIRST && hour_cnt <= tl_cfg_pkg::PEAK_AM_LAST)
               || (hour_cnt >= tl_cfg_pkg::PEAK_PM_FIRST && hour_cnt <= tl_cfg_pkg::PEAK_PM_LAST);

  assign o_hhmm = DW'(hour_cnt) * DW'(100) + DW'(min_cnt);

endmodule

/* hdl/duration_regs.sv */
// ----------------------------
// green and yellow lengths, stepped by the keys in the set modes
// ----------------------------
`timescale 1ns/1ns

module duration_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  tl_phase_pkg::mode_t   i_mode,
  input  logic                  i_plus_pulse,
  input  logic                  i_sub_pulse,
  tl_phase_if.settings          ph
);

  // plus wins if both keys release together
  function automatic logic [tl_cfg_pkg::CNT_W-1:0] step_len(
    input logic [tl_cfg_pkg::CNT_W-1:0] len,
    input logic                         plus,
    input logic                         sub
  );
    if (plus) begin
      return len + 1'b1;
    end
    if (sub) begin
      return len - 1'b1;
    end
    return len;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ph.green_len  <= tl_cfg_pkg::GREEN_DEFAULT;
      ph.yellow_len <= tl_cfg_pkg::YELLOW_DEFAULT;
    end else begin
      if (i_mode == tl_phase_pkg::MODE_SET_GREEN) begin
        ph.green_len <= step_len(ph.green_len, i_plus_pulse, i_sub_pulse);
      end
      if (i_mode == tl_phase_pkg::MODE_SET_YELLOW) begin
        ph.yellow_len <= step_len(ph.yellow_len, i_plus_pulse, i_sub_pulse);
      end
    end
  end

endmodule

/* hdl/phase_fsm.sv */
// ----------------------------
// phase sequencer with manual interrupts and the per-phase countdown
// ----------------------------
`timescale 1ns/1ns

module phase_fsm (
  input  logic                  clk,
  input  logic                  rst_n,
  input  tl_phase_pkg::mode_t   i_mode,
  input  logic                  i_plus_pulse,
  input  logic                  i_sub_pulse,
  input  logic                  i_tick,
  input  logic                  i_peak,
  tl_phase_if.fsm               ph
);

  logic                          run;
  logic                          night;
  logic                          start_q;
  logic                          int_q;
  tl_phase_pkg::phase_t          next_phase;
  logic [tl_cfg_pkg::CNT_W-1:0]  load_len;

  assign run   = (i_mode == tl_phase_pkg::MODE_RUN);
  assign night = (i_mode == tl_phase_pkg::MODE_NIGHT);

  always_comb begin
    case (ph.phase)
      tl_phase_pkg::G1:    next_phase = tl_phase_pkg::G1_Y;
      tl_phase_pkg::G1_Y:  next_phase = tl_phase_pkg::G1L;
      tl_phase_pkg::G1L:   next_phase = tl_phase_pkg::G1L_Y;
      tl_phase_pkg::G1L_Y: next_phase = tl_phase_pkg::G2;
      tl_phase_pkg::G2:    next_phase = tl_phase_pkg::G2_Y;
      tl_phase_pkg::G2_Y:  next_phase = tl_phase_pkg::G2L;
      tl_phase_pkg::G2L:   next_phase = tl_phase_pkg::G2L_Y;
      tl_phase_pkg::INT2:  next_phase = tl_phase_pkg::G2;
      // NIGHT, G2L_Y and INT1 all go to group 1 green
      default:             next_phase = tl_phase_pkg::G1;
    endcase
  end

  always_comb begin
    case (ph.phase)
      tl_phase_pkg::G1:    load_len = i_peak ? {ph.green_len[tl_cfg_pkg::CNT_W-2:0], 1'b0}
                                             : ph.green_len;
      tl_phase_pkg::G1L,
      tl_phase_pkg::G2,
      tl_phase_pkg::G2L:   load_len = ph.green_len;
      tl_phase_pkg::G1_Y,
      tl_phase_pkg::G1L_Y,
      tl_phase_pkg::G2_Y,
      tl_phase_pkg::G2L_Y: load_len = ph.yellow_len;
      tl_phase_pkg::INT1,
      tl_phase_pkg::INT2:  load_len = tl_cfg_pkg::INTERRUPT_SEC;
      default:             load_len = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ph.phase <= tl_phase_pkg::NIGHT;
      start_q  <= 1'b0;
      int_q    <= 1'b0;
    end else if (night) begin
      ph.phase <= tl_phase_pkg::NIGHT;
      start_q  <= 1'b0;
      int_q    <= 1'b0;
    end else if (run && !int_q && (i_sub_pulse || i_plus_pulse)) begin
      ph.phase <= i_sub_pulse ? tl_phase_pkg::INT1 : tl_phase_pkg::INT2;
      start_q  <= 1'b0;
      int_q    <= 1'b1;
    end else begin
      int_q <= 1'b0;
      // remain is stale while the interrupt length loads
      if (run && ph.remain == '0 && !start_q && !int_q) begin
        ph.phase <= next_phase;
        start_q  <= 1'b1;
      end else begin
        start_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ph.remain <= '0;
    end else if (night) begin
      ph.remain <= '0;
    end else if (start_q || int_q) begin
      ph.remain <= load_len;
    end else if (run && i_tick && ph.remain != '0) begin
      ph.remain <= ph.remain - 1'b1;
    end
  end

endmodule

/* hdl/lamp_decode.sv */
// ----------------------------
// phase to the twelve lamps, R Y G per group
// ----------------------------
`timescale 1ns/1ns

module lamp_decode (
  tl_phase_if.view     ph,
  output logic [11:0]  o_lamps
);

  localparam logic [2:0] RED = 3'b100;
  localparam logic [2:0] YEL = 3'b010;
  localparam logic [2:0] GRN = 3'b001;

  // group 1, group 1 left, group 2, group 2 left
  always_comb begin
    case (ph.phase)
      tl_phase_pkg::NIGHT: o_lamps = {YEL, YEL, YEL, YEL};
      tl_phase_pkg::G1:    o_lamps = {GRN, RED, RED, RED};
      tl_phase_pkg::G1_Y,
      tl_phase_pkg::INT1:  o_lamps = {YEL, RED, RED, RED};
      tl_phase_pkg::G1L:   o_lamps = {RED, GRN, RED, RED};
      tl_phase_pkg::G1L_Y: o_lamps = {RED, YEL, RED, RED};
      tl_phase_pkg::G2:    o_lamps = {RED, RED, GRN, RED};
      tl_phase_pkg::G2_Y,
      tl_phase_pkg::INT2:  o_lamps = {RED, RED, YEL, RED};
      tl_phase_pkg::G2L:   o_lamps = {RED, RED, RED, GRN};
      tl_phase_pkg::G2L_Y: o_lamps = {RED, RED, RED, YEL};
      // unused codes leave every lamp dark
      default:             o_lamps = '0;
    endcase
  end

endmodule

/* hdl/countdown_display.sv */
// ----------------------------
// two display values: time to green per group, a setting, or the clock
// ----------------------------
`timescale 1ns/1ns

module countdown_display (
  input  tl_phase_pkg::mode_t              i_mode,
  input  logic [tl_cfg_pkg::DISP_W-1:0]    i_hhmm,
  tl_phase_if.view                         ph,
  output logic [tl_cfg_pkg::DISP_W-1:0]    o_disp_a,
  output logic [tl_cfg_pkg::DISP_W-1:0]    o_disp_b
);

  localparam int DW = tl_cfg_pkg::DISP_W;

  logic [DW-1:0] rem_x;
  logic [DW-1:0] grn_x;
  logic [DW-1:0] yel_x;
  logic [DW-1:0] sum_a;
  logic [DW-1:0] sum_b;

  // wait seen by a group while the other road is served
  function automatic logic [DW-1:0] wait_sum(
    input tl_phase_pkg::phase_t cur,
    input tl_phase_pkg::phase_t grn_ph,
    input tl_phase_pkg::phase_t yel_ph,
    input tl_phase_pkg::phase_t left_ph,
    input logic [DW-1:0]        rem,
    input logic [DW-1:0]        grn,
    input logic [DW-1:0]        yel
  );
    if (cur == grn_ph) begin
      return rem + yel + yel + grn;
    end
    if (cur == yel_ph) begin
      return rem + yel + grn;
    end
    if (cur == left_ph) begin
      return rem + yel;
    end
    return rem;
  endfunction

  assign rem_x = DW'(ph.remain);
  assign grn_x = DW'(ph.green_len);
  assign yel_x = DW'(ph.yellow_len);

  assign sum_a = wait_sum(ph.phase, tl_phase_pkg::G2, tl_phase_pkg::G2_Y, tl_phase_pkg::G2L,
                          rem_x, grn_x, yel_x);
  assign sum_b = wait_sum(ph.phase, tl_phase_pkg::G1, tl_phase_pkg::G1_Y, tl_phase_pkg::G1L,
                          rem_x, grn_x, yel_x);

  always_comb begin
    case (i_mode)
      tl_phase_pkg::MODE_SET_GREEN: begin
        o_disp_a = grn_x;
        o_disp_b = i_hhmm;
      end
      tl_phase_pkg::MODE_SET_YELLOW: begin
        o_disp_a = yel_x;
        o_disp_b = i_hhmm;
      end
      default: begin
        o_disp_a = sum_a;
        o_disp_b = sum_b;
      end
    endcase
  end

endmodule

/* hdl/tl_top.sv */
// ----------------------------
// traffic-light controller top, plain ports for lamps, keys and displays
// ----------------------------
`timescale 1ns/1ns

module tl_top #(
  parameter int unsigned TICKS_PER_SEC = 12_000_000,
  parameter int unsigned RESET_HOUR    = 0
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [1:0]                     i_mode,
  input  logic                           i_key_plus,
  input  logic                           i_key_sub,
  output logic [11:0]                    o_lamps,
  output logic [tl_cfg_pkg::DISP_W-1:0]  o_disp_a,
  output logic [tl_cfg_pkg::DISP_W-1:0]  o_disp_b
);

  tl_phase_pkg::mode_t            mode;
  logic                           plus_pulse;
  logic                           sub_pulse;
  logic                           tick;
  logic                           peak;
  logic [tl_cfg_pkg::DISP_W-1:0]  hhmm;

  tl_phase_if ph_if ();

  key_sync u_key_sync (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mode       (i_mode),
    .i_key_plus   (i_key_plus),
    .i_key_sub    (i_key_sub),
    .o_mode       (mode),
    .o_plus_pulse (plus_pulse),
    .o_sub_pulse  (sub_pulse)
  );

  sec_clock #(
    .TICKS_PER_SEC (TICKS_PER_SEC),
    .RESET_HOUR    (RESET_HOUR)
  ) u_sec_clock (
    .clk    (clk),
    .rst_n  (rst_n),
    .o_tick (tick),
    .o_peak (peak),
    .o_hhmm (hhmm)
  );

  duration_regs u_duration_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mode       (mode),
    .i_plus_pulse (plus_pulse),
    .i_sub_pulse  (sub_pulse),
    .ph           (ph_if.settings)
  );

  phase_fsm u_phase_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mode       (mode),
    .i_plus_pulse (plus_pulse),
    .i_sub_pulse  (sub_pulse),
    .i_tick       (tick),
    .i_peak       (peak),
    .ph           (ph_if.fsm)
  );

  lamp_decode u_lamp_decode (
    .ph      (ph_if.view),
    .o_lamps (o_lamps)
  );

  countdown_display u_countdown_display (
    .i_mode   (mode),
    .i_hhmm   (hhmm),
    .ph       (ph_if.view),
    .o_disp_a (o_disp_a),
    .o_disp_b (o_disp_b)
  );

endmodule

/* tests/tl_checker.sv */
// ----------------------------
// reference model of the controller, compares lamps and displays
// ----------------------------
`timescale 1ns/1ns

module tl_checker #(
  parameter int unsigned TICKS_PER_SEC = 4,
  parameter int unsigned RESET_HOUR    = 7
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [1:0]                    i_mode,
  input  logic                          i_key_plus,
  input  logic                          i_key_sub,
  input  logic [11:0]                   i_lamps,
  input  logic [tl_cfg_pkg::DISP_W-1:0] i_disp_a,
  input  logic [tl_cfg_pkg::DISP_W-1:0] i_disp_b,
  input  logic                          i_row_end,
  input  int                            i_row_id,
  input  logic                          i_done,
  output int                            o_errors,
  output int                            o_checks
);

  localparam int CW = tl_cfg_pkg::CNT_W;
  localparam int DW = tl_cfg_pkg::DISP_W;

  tl_phase_pkg::phase_t m_phase;
  logic [CW-1:0]        m_remain;
  logic [CW-1:0]        m_green;
  logic [CW-1:0]        m_yellow;
  logic                 m_load;
  logic                 m_block;
  int unsigned          m_edges;
  int unsigned          m_hour;
  int unsigned          m_min;
  int unsigned          m_sec;
  // key releases, delayed until the controller sees them
  logic [1:0]           plus_d;
  logic [1:0]           sub_d;
  logic                 plus_prev;
  logic                 sub_prev;
  logic [11:0]          last_lamps;
  logic [11:0]          last_exp;
  int                   row_errors;

  function automatic logic is_peak(input int unsigned h);
    return (h >= tl_cfg_pkg::PEAK_AM_FIRST && h <= tl_cfg_pkg::PEAK_AM_LAST)
        || (h >= tl_cfg_pkg::PEAK_PM_FIRST && h <= tl_cfg_pkg::PEAK_PM_LAST);
  endfunction

  function automatic logic [CW-1:0] phase_len(input tl_phase_pkg::phase_t ph, input logic peak);
    case (ph)
      tl_phase_pkg::G1:    return peak ? CW'(m_green * 2) : m_green;
      tl_phase_pkg::G1L,
      tl_phase_pkg::G2,
      tl_phase_pkg::G2L:   return m_green;
      tl_phase_pkg::INT1,
      tl_phase_pkg::INT2:  return tl_cfg_pkg::INTERRUPT_SEC;
      tl_phase_pkg::NIGHT: return '0;
      default:             return m_yellow;
    endcase
  endfunction

  function automatic tl_phase_pkg::phase_t next_of(input tl_phase_pkg::phase_t ph);
    case (ph)
      tl_phase_pkg::G1:    return tl_phase_pkg::G1_Y;
      tl_phase_pkg::G1_Y:  return tl_phase_pkg::G1L;
      tl_phase_pkg::G1L:   return tl_phase_pkg::G1L_Y;
      tl_phase_pkg::G1L_Y: return tl_phase_pkg::G2;
      tl_phase_pkg::G2:    return tl_phase_pkg::G2_Y;
      tl_phase_pkg::G2_Y:  return tl_phase_pkg::G2L;
      tl_phase_pkg::G2L:   return tl_phase_pkg::G2L_Y;
      tl_phase_pkg::INT2:  return tl_phase_pkg::G2;
      default:             return tl_phase_pkg::G1;
    endcase
  endfunction

  // all red, then light the one group that is served
  function automatic logic [11:0] lamps_of(input tl_phase_pkg::phase_t ph);
    logic [11:0] l;
    l = 12'b100_100_100_100;
    case (ph)
      tl_phase_pkg::NIGHT: l = 12'b010_010_010_010;
      tl_phase_pkg::G1:    l[11:9] = 3'b001;
      tl_phase_pkg::G1_Y,
      tl_phase_pkg::INT1:  l[11:9] = 3'b010;
      tl_phase_pkg::G1L:   l[8:6] = 3'b001;
      tl_phase_pkg::G1L_Y: l[8:6] = 3'b010;
      tl_phase_pkg::G2:    l[5:3] = 3'b001;
      tl_phase_pkg::G2_Y,
      tl_phase_pkg::INT2:  l[5:3] = 3'b010;
      tl_phase_pkg::G2L:   l[2:0] = 3'b001;
      tl_phase_pkg::G2L_Y: l[2:0] = 3'b010;
      default:             l = '0;
    endcase
    return l;
  endfunction

  task automatic reset_model();
    m_phase   = tl_phase_pkg::NIGHT;
    m_remain  = '0;
    m_green   = tl_cfg_pkg::GREEN_DEFAULT;
    m_yellow  = tl_cfg_pkg::YELLOW_DEFAULT;
    m_load    = 1'b0;
    m_block   = 1'b0;
    m_edges   = 0;
    m_hour    = RESET_HOUR;
    m_min     = 0;
    m_sec     = 0;
    plus_d    = 2'b00;
    sub_d     = 2'b00;
    plus_prev = 1'b0;
    sub_prev  = 1'b0;
  endtask

  task automatic step_model();
    logic          tick;
    logic          plus;
    logic          sub;
    logic          run;
    logic          night;
    logic          old_load;
    logic          old_block;
    logic [CW-1:0] old_rem;
    logic [CW-1:0] len_now;
    plus      = plus_d[1];
    sub       = sub_d[1];
    tick      = (m_edges >= TICKS_PER_SEC) && (m_edges % TICKS_PER_SEC == 0);
    run       = (i_mode == tl_phase_pkg::MODE_RUN);
    night     = (i_mode == tl_phase_pkg::MODE_NIGHT);
    old_load  = m_load;
    old_block = m_block;
    old_rem   = m_remain;
    len_now   = phase_len(m_phase, is_peak(m_hour));
    if (night) begin
      m_phase = tl_phase_pkg::NIGHT;
      m_load  = 1'b0;
      m_block = 1'b0;
    end else if (run && !old_block && (plus || sub)) begin
      m_phase = sub ? tl_phase_pkg::INT1 : tl_phase_pkg::INT2;
      m_load  = 1'b1;
      m_block = 1'b1;
    end else begin
      m_block = 1'b0;
      m_load  = run && old_rem == '0 && !old_load && !old_block;
      if (m_load) begin
        m_phase = next_of(m_phase);
      end
    end
    // length of a new phase shows up one edge after it starts
    if (night) begin
      m_remain = '0;
    end else if (old_load) begin
      m_remain = len_now;
    end else if (run && tick && old_rem != '0) begin
      m_remain = old_rem - 1'b1;
    end
    if (i_mode == tl_phase_pkg::MODE_SET_GREEN) begin
      m_green = plus ? m_green + 1'b1 : (sub ? m_green - 1'b1 : m_green);
    end
    if (i_mode == tl_phase_pkg::MODE_SET_YELLOW) begin
      m_yellow = plus ? m_yellow + 1'b1 : (sub ? m_yellow - 1'b1 : m_yellow);
    end
    if (tick) begin
      m_sec = (m_sec + 1) % 60;
      if (m_sec == 0) begin
        m_min = (m_min + 1) % 60;
        if (m_min == 0) begin
          m_hour = (m_hour + 1) % 24;
        end
      end
    end
    m_edges++;
    plus_d    = {plus_d[0], plus_prev & ~i_key_plus};
    sub_d     = {sub_d[0], sub_prev & ~i_key_sub};
    plus_prev = i_key_plus;
    sub_prev  = i_key_sub;
  endtask

  task automatic check_field(input string name, input int unsigned got, input int unsigned exp);
    o_checks++;
    if (got != exp) begin
      o_errors++;
      row_errors++;
      $display("Error at %0t ns: %s is %0d, expected %0d in phase %s",
               $time, name, got, exp, m_phase.name());
    end
  endtask

  task automatic compare_outputs();
    int unsigned r;
    int unsigned g;
    int unsigned y;
    int unsigned exp_a;
    int unsigned exp_b;
    r = m_remain;
    g = m_green;
    y = m_yellow;
    exp_a = r;
    exp_b = r;
    case (m_phase)
      tl_phase_pkg::G2:   exp_a = r + 2 * y + g;
      tl_phase_pkg::G2_Y: exp_a = r + y + g;
      tl_phase_pkg::G2L:  exp_a = r + y;
      tl_phase_pkg::G1:   exp_b = r + 2 * y + g;
      tl_phase_pkg::G1_Y: exp_b = r + y + g;
      tl_phase_pkg::G1L:  exp_b = r + y;
      default:            exp_a = r;
    endcase
    if (i_mode == tl_phase_pkg::MODE_SET_GREEN || i_mode == tl_phase_pkg::MODE_SET_YELLOW) begin
      exp_a = (i_mode == tl_phase_pkg::MODE_SET_GREEN) ? g : y;
      exp_b = m_hour * 100 + m_min;
    end
    check_field("lamps", i_lamps, lamps_of(m_phase));
    check_field("disp_a", i_disp_a, exp_a % (1 << DW));
    check_field("disp_b", i_disp_b, exp_b % (1 << DW));
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      reset_model();
    end else begin
      step_model();
    end
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      o_errors   = 0;
      o_checks   = 0;
      row_errors = 0;
      last_lamps = i_lamps;
      last_exp   = lamps_of(m_phase);
    end else begin
      if (i_lamps != last_lamps || lamps_of(m_phase) != last_exp || i_row_end) begin
        compare_outputs();
      end
      last_lamps = i_lamps;
      last_exp   = lamps_of(m_phase);
      if (i_row_end) begin
        $display("test %0d finished with %0d errors", i_row_id, row_errors);
        row_errors = 0;
      end
      if (i_done) begin
        $display("checks %0d, errors %0d", o_checks, o_errors);
      end
    end
  end

endmodule

/* tests/tl_tb.sv */
// ----------------------------
// testbench for the controller, applies a table of mode and key rows
// ----------------------------
`timescale 1ns/1ns

module tl_tb;

  localparam int unsigned TPS = 4;
  localparam int          NROWS = 11;
  localparam logic [1:0]  KEY_NONE = 2'd0;
  localparam logic [1:0]  KEY_PLUS = 2'd1;
  localparam logic [1:0]  KEY_SUB  = 2'd2;

  // amount counts lamp changes when on_change is set and cycles otherwise
  typedef struct packed {
    logic [1:0]  mode;
    logic [1:0]  key;
    logic [3:0]  presses;
    logic        on_change;
    logic [15:0] amount;
    logic [15:0] budget;
  } row_t;

  logic                          clk;
  logic                          rst_n;
  logic [1:0]                    i_mode;
  logic                          i_key_plus;
  logic                          i_key_sub;
  logic [11:0]                   o_lamps;
  logic [tl_cfg_pkg::DISP_W-1:0] o_disp_a;
  logic [tl_cfg_pkg::DISP_W-1:0] o_disp_b;
  logic                          row_end;
  logic                          all_done;
  int                            row_id;
  int                            errors;
  int                            checks;
  int unsigned                   lamp_changes = 0;
  int unsigned                   cycle_cnt = 0;
  int unsigned                   cycle_limit = 32'hffff_ffff;
  logic [11:0]                   prev_lamps;
  row_t                          rows [NROWS];

  tl_top #(
    .TICKS_PER_SEC (TPS),
    .RESET_HOUR    (7)
  ) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_mode     (i_mode),
    .i_key_plus (i_key_plus),
    .i_key_sub  (i_key_sub),
    .o_lamps    (o_lamps),
    .o_disp_a   (o_disp_a),
    .o_disp_b   (o_disp_b)
  );

  tl_checker #(
    .TICKS_PER_SEC (TPS),
    .RESET_HOUR    (7)
  ) chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_mode     (i_mode),
    .i_key_plus (i_key_plus),
    .i_key_sub  (i_key_sub),
    .i_lamps    (o_lamps),
    .i_disp_a   (o_disp_a),
    .i_disp_b   (o_disp_b),
    .i_row_end  (row_end),
    .i_row_id   (row_id),
    .i_done     (all_done),
    .o_errors   (errors),
    .o_checks   (checks)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(negedge clk) begin
    if (rst_n && o_lamps != prev_lamps) begin
      lamp_changes = lamp_changes + 1;
    end
    prev_lamps = o_lamps;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the lamps stopped following the rows", cycle_cnt);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic load_table();
    // full cycle at peak hour of 60 5 30 5 30 5 30 5
    rows[0]  = '{tl_phase_pkg::MODE_RUN, KEY_NONE, 4'd0, 1'b1, 16'd9, 16'd760};
    rows[1]  = '{tl_phase_pkg::MODE_NIGHT, KEY_NONE, 4'd0, 1'b0, 16'd20, 16'd20};
    rows[2]  = '{tl_phase_pkg::MODE_RUN, KEY_NONE, 4'd0, 1'b1, 16'd1, 16'd10};
    rows[3]  = '{tl_phase_pkg::MODE_SET_GREEN, KEY_PLUS, 4'd3, 1'b0, 16'd8, 16'd40};
    rows[4]  = '{tl_phase_pkg::MODE_SET_YELLOW, KEY_SUB, 4'd2, 1'b0, 16'd8, 16'd30};
    // new lengths of 66 3 33 3 33 3 33 3
    rows[5]  = '{tl_phase_pkg::MODE_RUN, KEY_NONE, 4'd0, 1'b1, 16'd8, 16'd760};
    rows[6]  = '{tl_phase_pkg::MODE_RUN, KEY_NONE, 4'd0, 1'b1, 16'd4, 16'd460};
    rows[7]  = '{tl_phase_pkg::MODE_RUN, KEY_NONE, 4'd0, 1'b0, 16'd40, 16'd40};
    // group 1 interrupt from G2 and group 2 interrupt from G1
    rows[8]  = '{tl_phase_pkg::MODE_RUN, KEY_SUB, 4'd1, 1'b1, 16'd2, 16'd48};
    rows[9]  = '{tl_phase_pkg::MODE_RUN, KEY_PLUS, 4'd1, 1'b1, 16'd2, 16'd48};
    rows[10] = '{tl_phase_pkg::MODE_RUN, KEY_NONE, 4'd0, 1'b0, 16'd16, 16'd16};
  endtask

  task automatic press_key(input logic [1:0] key);
    int unsigned hold;
    hold = 1 + ($urandom % 4);
    @(posedge clk);
    if (key == KEY_PLUS) begin
      i_key_plus <= 1'b1;
    end else begin
      i_key_sub <= 1'b1;
    end
    repeat (hold) @(posedge clk);
    i_key_plus <= 1'b0;
    i_key_sub  <= 1'b0;
    // release pulse reaches the FSM three edges later
    repeat (5) @(posedge clk);
  endtask

  task automatic run_row(input int r);
    int unsigned start;
    @(posedge clk);
    i_mode <= rows[r].mode;
    start = lamp_changes;
    for (int p = 0; p < int'(rows[r].presses); p++) begin
      press_key(rows[r].key);
    end
    if (rows[r].on_change) begin
      while (lamp_changes < start + rows[r].amount) begin
        @(posedge clk);
      end
    end else begin
      repeat (rows[r].amount) @(posedge clk);
    end
    row_id  <= r;
    row_end <= 1'b1;
    @(posedge clk);
    row_end <= 1'b0;
  endtask

  initial begin
    int unsigned budget_sum;
    void'($urandom(32'h6f86_7637));
    load_table();
    budget_sum = 0;
    foreach (rows[r]) begin
      budget_sum += rows[r].budget;
    end
    cycle_limit = budget_sum * 2 + 200;
    rst_n      = 1'b0;
    i_mode     = tl_phase_pkg::MODE_RUN;
    i_key_plus = 1'b0;
    i_key_sub  = 1'b0;
    row_end    = 1'b0;
    all_done   = 1'b0;
    row_id     = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end
    @(posedge clk);
    all_done <= 1'b1;
    @(posedge clk);
    all_done <= 1'b0;
    @(posedge clk);
    if (errors == 0 && checks > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
hdl/tl_cfg_pkg.sv
hdl/tl_phase_pkg.sv
hdl/tl_phase_if.sv
hdl/key_sync.sv
hdl/sec_clock.sv
hdl/duration_regs.sv
hdl/phase_fsm.sv
hdl/lamp_decode.sv
hdl/countdown_display.sv
hdl/tl_top.sv
tests/tl_checker.sv
tests/tl_tb.sv

/* run.sh */
#!/bin/sh
# build the traffic-light testbench with Verilator, run it and look for the pass line
verilator --binary --timing -Wno-fatal --top-module tl_tb -f files.f -o tl_sim || exit 1
out=$(./obj_dir/tl_sim)
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS" && exit 0 || exit 1
